// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int xlen       = 32;                 // Data and address width
    localparam int reg_addr_w = 5;                  // x0..x31

    // Major opcodes of the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000;        // ADD, SUB, ADDI
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;        // LW and SW
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [1:0] {
        res_alu  = 2'b00,
        res_load = 2'b01,                           // Same code as the old hazard block
        res_none = 2'b10                            // No register write
    } result_sel_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,                           // Register file value
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_t;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_or} alu_op_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;                     // All zero decodes as a no-op
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_t               alu_op;
        logic                  alu_src_imm;
        result_sel_t           result_sel;
        logic                  mem_write;
        logic                  is_branch;
        logic                  valid;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rs2;                 // Kept for WB-to-MEM store forwarding
        logic [reg_addr_w-1:0] rd;
        result_sel_t           result_sel;
        logic                  mem_write;
        logic                  valid;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       wb_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  valid;
    } mem_wb_t;

endpackage

// ==== verilog/hazard_if.sv ====
`timescale 1ns/1ps
interface hazard_if import core_pkg::*; (
    input logic clk,
    input logic rst_n
);
    logic [reg_addr_w-1:0] rs1_id, rs2_id;          // ID sources, zero when unused
    logic [reg_addr_w-1:0] rs1_ex, rs2_ex, rd_ex;
    result_sel_t           result_sel_ex;
    logic                  branch_taken;            // Resolved in EX
    logic [reg_addr_w-1:0] rd_mem, rs2_mem;
    logic                  reg_write_mem;           // ALU write only, loads excluded
    logic [reg_addr_w-1:0] rd_wb;
    logic                  reg_write_wb;

    logic     stall_if, stall_if_id;
    logic     flush_if_id, flush_id_ex;
    fwd_sel_t fwd_a, fwd_b;
    logic     fwd_store;

    modport fetch_mp   (input stall_if, stall_if_id, flush_if_id, branch_taken);
    modport decode_mp  (output rs1_id, rs2_id, input flush_id_ex);
    modport execute_mp (output rs1_ex, rs2_ex, rd_ex, result_sel_ex, branch_taken,
                        input fwd_a, fwd_b);
    modport result_mp  (output rd_mem, rs2_mem, reg_write_mem, rd_wb, reg_write_wb,
                        input fwd_store);
    modport hazard_mp  (input clk, rst_n, rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex,
                        result_sel_ex, branch_taken, rd_mem, rs2_mem, reg_write_mem,
                        rd_wb, reg_write_wb,
                        output stall_if, stall_if_id, flush_if_id, flush_id_ex,
                        fwd_a, fwd_b, fwd_store);
endinterface

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,                         // Hold current contents
    input  logic     flush,                         // Insert a bubble
    input  payload_t d,
    output payload_t q
);

    // Whole payload goes to zero on a bubble
    // valid drops with it and a zero instruction word is a no-op
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
module fetch_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    hazard_if.fetch_mp      hz,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    input  logic [xlen-1:0] branch_target,          // From EX
    output if_id_t          if_id
);

    logic [xlen-1:0] pc;
    if_id_t          if_id_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (hz.branch_taken) begin
            pc <= branch_target;                    // Redirect wins, never seen with a stall
        end else if (!hz.stall_if) begin
            pc <= pc + xlen'(4);
        end
    end

    assign imem_addr     = pc;                      // Combinational read outside
    assign if_id_d.pc    = pc;
    assign if_id_d.instr = imem_data;

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n(rst_n), .stall(hz.stall_if_id), .flush(hz.flush_if_id),
        .d(if_id_d), .q(if_id)
    );

    // Load-use and taken branch must never meet on the front register
    a_no_stall_and_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(hz.stall_if_id && hz.flush_if_id));

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
module decode_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  if_id_t     if_id,
    hazard_if.decode_mp hz,
    input  mem_wb_t    wb,                          // Writeback port of the register file
    output id_ex_t     id_ex
);

    logic [xlen-1:0] regs [32];
    id_ex_t          dec;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] instr;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // x0 reads zero, a WB write to the same register is seen in this cycle
    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] a);
        if (a == '0) begin
            return '0;
        end
        if (wb.valid && wb.reg_write && wb.rd == a) begin
            return wb.wb_data;                      // Write-through
        end
        return regs[a];
    endfunction

    always_comb begin
        dec            = '0;                        // Unknown opcode stays a no-op
        dec.pc         = if_id.pc;
        dec.result_sel = res_none;
        dec.alu_op     = alu_add;
        case (opcode)
            op_rtype: begin
                dec.rs1        = instr[19:15];
                dec.rs2        = instr[24:20];
                dec.rd         = instr[11:7];
                dec.result_sel = res_alu;
                dec.valid      = 1'b1;
                case (funct3)
                    f3_add:  dec.alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_and:  dec.alu_op = alu_and;
                    f3_or:   dec.alu_op = alu_or;
                    default: begin
                        dec.result_sel = res_none;  // Outside the subset
                        dec.valid      = 1'b0;
                    end
                endcase
            end
            op_itype: begin
                if (funct3 == f3_add) begin         // ADDI only
                    dec.rs1         = instr[19:15];
                    dec.rd          = instr[11:7];
                    dec.imm         = {{20{instr[31]}}, instr[31:20]};
                    dec.alu_src_imm = 1'b1;
                    dec.result_sel  = res_alu;
                    dec.valid       = 1'b1;
                end
            end
            op_load: begin
                if (funct3 == f3_word) begin
                    dec.rs1         = instr[19:15];
                    dec.rd          = instr[11:7];
                    dec.imm         = {{20{instr[31]}}, instr[31:20]};
                    dec.alu_src_imm = 1'b1;         // Address = rs1 + imm
                    dec.result_sel  = res_load;
                    dec.valid       = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == f3_word) begin
                    dec.rs1         = instr[19:15];
                    dec.rs2         = instr[24:20]; // Store data source
                    dec.imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    dec.alu_src_imm = 1'b1;
                    dec.mem_write   = 1'b1;
                    dec.valid       = 1'b1;
                end
            end
            op_branch: begin
                if (funct3 == f3_beq) begin
                    dec.rs1       = instr[19:15];
                    dec.rs2       = instr[24:20];
                    dec.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                     instr[11:8], 1'b0};
                    dec.is_branch = 1'b1;
                    dec.valid     = 1'b1;
                end
            end
            default: ;
        endcase
        dec.rs1_val = read_reg(dec.rs1);
        dec.rs2_val = read_reg(dec.rs2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

    assign hz.rs1_id = dec.rs1;                     // Zero when not a real source
    assign hz.rs2_id = dec.rs2;

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(hz.flush_id_ex),
        .d(dec), .q(id_ex)
    );

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
module execute_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  id_ex_t          id_ex,
    hazard_if.execute_mp    hz,
    input  logic [xlen-1:0] mem_fwd,                // ALU result sitting in MEM
    input  logic [xlen-1:0] wb_fwd,                 // Value being written back
    output ex_mem_t         ex_mem,
    output logic [xlen-1:0] branch_target
);

    logic [xlen-1:0] op_a, op_b;                    // Forwarded register operands
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;
    ex_mem_t         ex_mem_d;

    always_comb begin
        case (hz.fwd_a)
            fwd_mem: op_a = mem_fwd;
            fwd_wb:  op_a = wb_fwd;
            default: op_a = id_ex.rs1_val;
        endcase
        case (hz.fwd_b)
            fwd_mem: op_b = mem_fwd;
            fwd_wb:  op_b = wb_fwd;
            default: op_b = id_ex.rs2_val;
        endcase
    end

    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_res = op_a - alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_or:  alu_res = op_a | alu_b;
            default: alu_res = op_a + alu_b;
        endcase
    end

    // BEQ compares the forwarded registers, target is PC relative
    assign branch_target   = id_ex.pc + id_ex.imm;
    assign hz.branch_taken = id_ex.valid && id_ex.is_branch && (op_a == op_b);

    assign hz.rs1_ex        = id_ex.rs1;
    assign hz.rs2_ex        = id_ex.rs2;
    assign hz.rd_ex         = id_ex.rd;
    assign hz.result_sel_ex = id_ex.result_sel;

    assign ex_mem_d.alu_res    = alu_res;
    assign ex_mem_d.store_data = op_b;              // Forwarded rs2, not the immediate
    assign ex_mem_d.rs2        = id_ex.rs2;
    assign ex_mem_d.rd         = id_ex.rd;
    assign ex_mem_d.result_sel = id_ex.result_sel;
    assign ex_mem_d.mem_write  = id_ex.mem_write;
    assign ex_mem_d.valid      = id_ex.valid;

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem)
    );

    // The slot behind a taken branch is squashed
    a_branch_squash: assert property (@(posedge clk) disable iff (!rst_n)
        hz.branch_taken |=> !id_ex.valid);

endmodule

// ==== verilog/result_stage.sv ====
`timescale 1ns/1ps
module result_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ex_mem_t               ex_mem,
    hazard_if.result_mp           hz,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    output logic                  dmem_we,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic [xlen-1:0]       mem_fwd,
    output mem_wb_t               wb,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    mem_wb_t mem_wb_d;

    assign dmem_addr  = ex_mem.alu_res;
    assign dmem_wdata = hz.fwd_store ? wb.wb_data : ex_mem.store_data;  // Late rs2 from WB
    assign dmem_we    = ex_mem.valid && ex_mem.mem_write;
    assign mem_fwd    = ex_mem.alu_res;

    assign hz.rd_mem        = ex_mem.rd;
    assign hz.rs2_mem       = ex_mem.rs2;
    assign hz.reg_write_mem = ex_mem.valid && ex_mem.result_sel == res_alu && ex_mem.rd != '0;

    // Load data is only ready here, so it joins the ALU result at MEM/WB
    assign mem_wb_d.wb_data   = (ex_mem.result_sel == res_load) ? dmem_rdata : ex_mem.alu_res;
    assign mem_wb_d.rd        = ex_mem.rd;
    assign mem_wb_d.reg_write = ex_mem.valid && ex_mem.result_sel != res_none
                                && ex_mem.rd != '0;
    assign mem_wb_d.valid     = ex_mem.valid;

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .d(mem_wb_d), .q(wb)
    );

    assign hz.rd_wb        = wb.rd;
    assign hz.reg_write_wb = wb.valid && wb.reg_write;

    assign wb_valid = wb.valid && wb.reg_write && wb.rd != '0;  // x0 writes stay silent
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.wb_data;

    a_we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(dmem_we));

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
module hazard_unit import core_pkg::*; (
    hazard_if.hazard_mp hz
);

    logic load_use;

    // MEM result first, then WB; x0 is never forwarded
    function automatic fwd_sel_t pick_fwd(input logic [reg_addr_w-1:0] rs);
        if (rs == '0) begin
            return fwd_none;
        end
        if (hz.reg_write_mem && hz.rd_mem == rs) begin
            return fwd_mem;                         // Loads never get here
        end
        if (hz.reg_write_wb && hz.rd_wb == rs) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        hz.fwd_a     = pick_fwd(hz.rs1_ex);
        hz.fwd_b     = pick_fwd(hz.rs2_ex);
        // Store data in MEM picks up a value that lands in WB right now
        hz.fwd_store = hz.reg_write_wb && hz.rd_wb != '0 && hz.rd_wb == hz.rs2_mem;
    end

    // Load in EX feeding the instruction in ID
    assign load_use = hz.result_sel_ex == res_load && hz.rd_ex != '0
                      && (hz.rd_ex == hz.rs1_id || hz.rd_ex == hz.rs2_id);

    always_comb begin
        hz.stall_if    = load_use;                  // PC holds
        hz.stall_if_id = load_use;                  // ID instruction waits one cycle
        hz.flush_if_id = hz.branch_taken;           // Wrong-path fetch
        hz.flush_id_ex = load_use || hz.branch_taken;  // Bubble or squash
    end

    // The bubble behind a stalled load releases the waiting instruction after one cycle
    a_load_use_one_cycle: assert property (@(posedge hz.clk) disable iff (!hz.rst_n)
        load_use |=> !load_use);

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps
module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [xlen-1:0]       imem_addr,
    input  logic [xlen-1:0]       imem_data,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    output logic                  dmem_we,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] mem_fwd;

    hazard_if hz (.clk(clk), .rst_n(rst_n));

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .hz(hz.fetch_mp),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .branch_target(branch_target), .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .if_id(if_id), .hz(hz.decode_mp),
        .wb(mem_wb), .id_ex(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .hz(hz.execute_mp),
        .mem_fwd(mem_fwd), .wb_fwd(mem_wb.wb_data),  // WB value for operand forwarding
        .ex_mem(ex_mem), .branch_target(branch_target)
    );

    result_stage u_result (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .hz(hz.result_mp),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .mem_fwd(mem_fwd), .wb(mem_wb),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    hazard_unit u_hazard (.hz(hz.hazard_mp));

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);                 // Reset held for 10 cycles
        rst_n <= 1'b1;                              // Released on a rising edge
    end

endmodule

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps
module tb_checker import core_pkg::*; #(
    parameter int fetch_limit = 0                   // Highest fetch address the program reaches
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [xlen-1:0]            imem_addr,
    input  logic                       wb_valid,
    input  logic [reg_addr_w-1:0]      wb_rd,
    input  logic [xlen-1:0]            wb_data,
    input  logic                       dmem_we,
    input  logic [xlen-1:0]            dmem_addr,
    input  logic [xlen-1:0]            dmem_wdata,
    input  logic [reg_addr_w+xlen-1:0] exp_wb [64],   // {rd, value} in program order
    input  int                         n_wb,
    input  logic [2*xlen-1:0]          exp_st [64],   // {address, data}
    input  int                         n_st,
    input  logic                       report_req,
    output logic                       all_seen,
    output logic                       report_done,
    output int                         err_total
);

    int   wb_idx     = 0;                           // Next expected writeback
    int   st_idx     = 0;                           // Next expected store
    int   wb_errs    = 0;
    int   st_errs    = 0;
    int   other_errs = 0;                           // Missing, extra or misplaced events
    logic seen_edge  = 1'b0;
    logic reported   = 1'b0;

    assign all_seen    = (wb_idx == n_wb) && (st_idx == n_st);
    assign report_done = reported;
    assign err_total   = wb_errs + st_errs + other_errs;

    task automatic compare_writeback();
        logic [reg_addr_w-1:0] e_rd;
        logic [xlen-1:0]       e_data;
        if (wb_rd == '0) begin
            $display("wb_valid raised for a write to x0 at %0d ns", $time);
            other_errs++;
        end else if (wb_idx >= n_wb) begin
            $display("Extra writeback to x%0d at %0d ns, none left to expect", wb_rd, $time);
            other_errs++;
        end else begin
            {e_rd, e_data} = exp_wb[wb_idx];
            wb_idx++;
            if (wb_rd !== e_rd) begin
                $display("** Error at %0d ns: wb_rd expected x%0d, got x%0d", $time, e_rd, wb_rd);
                wb_errs++;
            end
            if (wb_data !== e_data) begin
                $display("** Error at %0d ns: wb_data expected %h, got %h",
                         $time, e_data, wb_data);
                wb_errs++;
            end
        end
    endtask

    task automatic match_store();
        logic [xlen-1:0] e_addr;
        logic [xlen-1:0] e_data;
        if (st_idx >= n_st) begin
            $display("Extra store to address %h at %0d ns, none left to expect", dmem_addr, $time);
            other_errs++;
        end else begin
            {e_addr, e_data} = exp_st[st_idx];
            st_idx++;
            if (dmem_addr !== e_addr) begin
                $display("** Error at %0d ns: dmem_addr expected %h, got %h",
                         $time, e_addr, dmem_addr);
                st_errs++;
            end
            if (dmem_wdata !== e_data) begin
                $display("** Error at %0d ns: dmem_wdata expected %h, got %h",
                         $time, e_data, dmem_wdata);
                st_errs++;
            end
        end
    endtask

    // Fetch stays word aligned and never runs past the slots behind the self-loop
    task automatic check_fetch();
        if (imem_addr[1:0] !== 2'b00 || imem_addr > xlen'(fetch_limit)) begin
            $display("Fetch address %h at %0d ns is misaligned or beyond the program",
                     imem_addr, $time);
            other_errs++;
        end
    endtask

    always @(posedge clk) seen_edge <= 1'b1;

    // Falling edge: pipeline outputs settled, memory write not yet taken
    always @(negedge clk) begin
        if (seen_edge && !rst_n) begin
            if (wb_valid !== 1'b0 || dmem_we !== 1'b0) begin
                $display("Writeback or store strobe active during reset at %0d ns", $time);
                other_errs++;
            end
        end else if (rst_n) begin
            check_fetch();
            if (wb_valid === 1'b1) compare_writeback();
            if (dmem_we === 1'b1) match_store();
        end
        if (report_req && !reported) begin
            if (wb_idx != n_wb) begin
                $display("%0d expected writebacks never appeared", n_wb - wb_idx);
                other_errs++;
            end
            if (st_idx != n_st) begin
                $display("%0d expected stores never appeared", n_st - st_idx);
                other_errs++;
            end
            $display("Errors: writeback %0d, store %0d, other %0d", wb_errs, st_errs, other_errs);
            reported = 1'b1;
        end
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps
module tb_top import core_pkg::*; ();

    localparam int n_instr  = 40;                   // Program length before the self-loop
    localparam int loop_pc  = n_instr * 4;
    localparam int limit_ns = (n_instr * 4 + 60) * 4;  // 4 cycles each, plus reset and drain

    logic                       clk, rst_n;
    logic [xlen-1:0]            imem_addr, imem_data;
    logic [xlen-1:0]            dmem_addr, dmem_wdata, dmem_rdata;
    logic                       dmem_we;
    logic                       wb_valid;
    logic [reg_addr_w-1:0]      wb_rd;
    logic [xlen-1:0]            wb_data;

    logic [xlen-1:0]            imem [64];          // Word addressed
    logic [xlen-1:0]            dmem [64];
    logic [reg_addr_w+xlen-1:0] exp_wb [64];
    logic [2*xlen-1:0]          exp_st [64];
    int                         n_wb, n_st;
    integer                     seed = 32'h942d4da5;
    logic                       report_req, report_done, all_seen, timed_out;
    int                         err_total;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    core_top u_dut (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    // Two slots behind the self-loop are fetched before its redirect
    tb_checker #(.fetch_limit(loop_pc + 8)) u_checker (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .exp_wb(exp_wb), .n_wb(n_wb), .exp_st(exp_st), .n_st(n_st),
        .report_req(report_req), .all_seen(all_seen), .report_done(report_done),
        .err_total(err_total)
    );

    // Combinational reads, store lands on the rising edge
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];
    always @(posedge clk) begin
        if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [xlen-1:0] data_fill(input int i);
        return (32'(i) + 32'h0000_1001) * 32'h9e37_79b9;  // Every address bit matters
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [2:0] f3, input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, f3_word, imm[4:0], op_store};   // Base is x0
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs1, rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3_beq, imm[4:1], imm[11], op_branch};
    endfunction

    // Random program over x0..x7 so hazards crowd together
    task automatic build_program();
        int         kind;
        logic [4:0] rd, rs1, rs2;
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_type(op_itype, 12'(i), f3_add, 5'd0, 5'd0);  // addi x0 filler
            dmem[i] = data_fill(i);
        end
        for (int i = 0; i < n_instr; i++) begin
            kind = rand_below(8);
            rd   = 5'(rand_below(8));
            rs1  = 5'(rand_below(8));
            rs2  = 5'(rand_below(8));
            if (kind == 7 && i > n_instr - 3) kind = 4;  // Target would pass the loop
            case (kind)
                0: imem[i] = r_type(7'd0, f3_add, rd, rs1, rs2);
                1: imem[i] = r_type(f7_sub, f3_add, rd, rs1, rs2);
                2: imem[i] = r_type(7'd0, f3_and, rd, rs1, rs2);
                3: imem[i] = r_type(7'd0, f3_or, rd, rs1, rs2);
                4: imem[i] = i_type(op_itype, 12'(rand_below(4096)), f3_add, rd, rs1);
                5: imem[i] = i_type(op_load, 12'(4 * rand_below(16)), f3_word, rd, 5'd0);
                6: imem[i] = s_type(12'(4 * rand_below(16)), rs2);
                default: begin
                    if (rand_below(2) == 1) rs2 = rs1;   // Forces a taken branch
                    imem[i] = b_type(rand_below(2) == 1 ? 13'd12 : 13'd8, rs1, rs2);
                end
            endcase
        end
        imem[n_instr] = b_type(13'd0, 5'd0, 5'd0);  // Self-loop
    endtask

    // Instruction-set model, fills the expected writeback and store lists
    function automatic void run_reference();
        logic [xlen-1:0] x [32];
        logic [xlen-1:0] mem [64];
        logic [xlen-1:0] pc, pc_next, ins, a, b, res, addr;
        logic [xlen-1:0] imm_i, imm_s, imm_b;
        logic [4:0]      rd;
        logic            wr;
        int              steps;
        n_wb  = 0;
        n_st  = 0;
        pc    = '0;
        steps = 0;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 64; i++) mem[i] = data_fill(i);
        while (pc != loop_pc && steps < 4 * n_instr) begin
            ins     = imem[pc[7:2]];
            rd      = ins[11:7];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            res     = '0;
            wr      = 1'b0;
            pc_next = pc + 32'd4;
            case (ins[6:0])
                op_rtype: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        default: res = ins[30] ? a - b : a + b;
                    endcase
                end
                op_itype: begin
                    wr  = 1'b1;
                    res = a + imm_i;
                end
                op_load: begin
                    wr   = 1'b1;
                    addr = a + imm_i;
                    res  = mem[addr[7:2]];
                end
                op_store: begin
                    addr              = a + imm_s;
                    mem[addr[7:2]]    = b;
                    exp_st[n_st]      = {addr, b};
                    n_st++;
                end
                op_branch: if (a == b) pc_next = pc + imm_b;
                default: ;
            endcase
            if (wr && rd != 5'd0) begin             // x0 writes are invisible
                x[rd]        = res;
                exp_wb[n_wb] = {rd, res};
                n_wb++;
            end
            pc = pc_next;
            steps++;
        end
    endfunction

    initial begin
        report_req = 1'b0;
        timed_out  = 1'b0;
        build_program();
        run_reference();
        fork
            begin
                wait (rst_n === 1'b1);
                wait (all_seen);
                repeat (20) @(posedge clk);         // Self-loop must stay silent
            end
            begin
                #(limit_ns);
                timed_out = 1'b1;
            end
        join_any
        if (timed_out) begin
            $display("Timeout: the program did not retire within %0d ns", limit_ns);
        end
        report_req = 1'b1;
        wait (report_done);
        @(posedge clk);                             // Let the error total settle
        if (timed_out || err_total != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/core_pkg.sv
verilog/hazard_if.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/hazard_unit.sv
verilog/core_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_top -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }

# The run passes only if the pass line shows up in the simulator output
./obj_dir/tb_sim | tee /dev/stderr | grep -x "All checks passed" > /dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
